// ==== include/core_consts.svh ====
// core-wide width and size constants
// register file reset pattern

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data word width
`define CORE_XLEN 32

// register index width
`define CORE_REG_IDX_W 5

// architectural registers, x0 included
`define CORE_NUM_REGS 32

// pattern in x1..x31 after reset
// easy to spot in waveforms
`define CORE_REG_RESET_VAL 32'hDEADBEEF

`endif

// ==== hdl/core_pkg.sv ====
// shared core types
// word and register index, decoded opcode class, handshake states

`include "core_consts.svh"

package core_pkg;

    // one data word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // architectural register index
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

    // decoded instruction class
    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_alu_imm,
        op_alu_reg,
        // csr, fence, ecall and anything unknown end up here
        op_illegal
    } opcode_t;

    // fetch side handshake
    typedef enum logic [1:0] {
        // ack low, ready for a request
        in_idle,
        // ack high until fetch drops req
        in_ack_wait_low,
        // ack just dropped, one quiet cycle
        in_hold
    } hs_in_state_t;

    // execute side handshake and slot occupancy
    typedef enum logic [1:0] {
        // slot free
        out_empty,
        // req high until execute acks
        out_req_high,
        // req low, slot held until ack drops
        out_wait_ack_low
    } hs_out_state_t;

endpackage : core_pkg

// ==== hdl/core_s2_reg_file.sv ====
// integer register file
// one write port, two combinational read ports, x0 hardwired to zero

`timescale 1ns/10ps

`include "core_consts.svh"

module core_s2_reg_file (
    input  logic               clk,
    input  logic               rst_n,

    // write port
    input  core_pkg::reg_idx_t rd_idx,
    input  core_pkg::word_t    rd_wd,
    input  logic               rd_we,

    // read port 1
    input  core_pkg::reg_idx_t rs1_idx,
    output core_pkg::word_t    rs1_ff,

    // read port 2
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t    rs2_ff
);

    import core_pkg::*;

    // x1..x31 only, x0 has no storage
    word_t reg_ff [`CORE_NUM_REGS-1:1];

    // one-hot write enables
    logic [`CORE_NUM_REGS-1:1] reg_we;

    // write enable decoder
    // index 0 matches no entry so its writes vanish
    always_comb begin
        for (int i = 1; i < `CORE_NUM_REGS; i++) begin
            reg_we[i] = rd_we && (rd_idx == reg_idx_t'(i));
        end
    end

    // storage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // known junk pattern
            for (int i = 1; i < `CORE_NUM_REGS; i++) begin
                reg_ff[i] <= `CORE_REG_RESET_VAL;
            end
        end else begin
            for (int i = 1; i < `CORE_NUM_REGS; i++) begin
                if (reg_we[i]) begin
                    reg_ff[i] <= rd_wd;
                end
            end
        end
    end

    // read muxes
    // a write on this edge shows up only after the edge
    assign rs1_ff = (rs1_idx == '0) ? '0 : reg_ff[rs1_idx];
    assign rs2_ff = (rs2_idx == '0) ? '0 : reg_ff[rs2_idx];

    // an unknown enable would corrupt any entry silently
    a_we_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_we)
    ) else $error("register file write enable is unknown");

endmodule : core_s2_reg_file

// ==== hdl/core_s2_decoder.sv ====
// combinational rv32i decoder
// major opcode classification, register fields, immediate generation

`timescale 1ns/10ps

`include "core_consts.svh"

module core_s2_decoder (
    input  core_pkg::word_t    instr,
    output core_pkg::opcode_t  opcode,
    output core_pkg::reg_idx_t rd_idx,
    output core_pkg::reg_idx_t rs1_idx,
    output core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t    imm,
    output logic [2:0]         funct3,
    output logic               funct7_b5
);

    import core_pkg::*;

    // candidate immediates, one per format
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // sign bit of every format
    logic  sign;

    // fixed field positions
    assign rd_idx    = instr[11:7];
    assign rs1_idx   = instr[19:15];
    assign rs2_idx   = instr[24:20];
    assign funct3    = instr[14:12];
    // sub/sra select
    assign funct7_b5 = instr[30];

    assign sign = instr[31];

    // i format: jalr, loads, alu immediates
    assign imm_i = {{(`CORE_XLEN-12){sign}}, instr[31:20]};

    // s format: split across rd field
    assign imm_s = {{(`CORE_XLEN-12){sign}}, instr[31:25], instr[11:7]};

    // b format: scrambled, bit 0 implied zero
    assign imm_b = {
        {(`CORE_XLEN-13){sign}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    // u format: upper 20 bits
    assign imm_u = {instr[31:12], 12'b0};

    // j format: scrambled, bit 0 implied zero
    assign imm_j = {
        {(`CORE_XLEN-21){sign}},
        instr[31],
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

    // major opcode classification
    always_comb begin
        opcode = op_illegal;
        // compressed encodings not supported
        if (instr[1:0] == 2'b11) begin
            case (instr[6:2])
                5'b01101: opcode = op_lui;
                5'b00101: opcode = op_auipc;
                5'b11011: opcode = op_jal;
                5'b11001: opcode = op_jalr;
                5'b11000: opcode = op_branch;
                5'b00000: opcode = op_load;
                5'b01000: opcode = op_store;
                5'b00100: opcode = op_alu_imm;
                5'b01100: opcode = op_alu_reg;
                // system, misc-mem and the rest
                default:  opcode = op_illegal;
            endcase
        end
    end

    // immediate select by class
    always_comb begin
        case (opcode)
            op_lui,
            op_auipc:   imm = imm_u;
            op_jal:     imm = imm_j;
            op_jalr,
            op_load,
            op_alu_imm: imm = imm_i;
            op_branch:  imm = imm_b;
            op_store:   imm = imm_s;
            // register ops and illegal carry no immediate
            default:    imm = '0;
        endcase
    end

endmodule : core_s2_decoder

// ==== hdl/core_s2_ctrl.sv ====
// decode stage control
// fetch and execute four-phase handshake FSMs, output slot register

`timescale 1ns/10ps

`include "core_consts.svh"

module core_s2_ctrl (
    input  logic               clk,
    input  logic               rst_n,

    // fetch side
    input  logic               in_req,
    output logic               in_ack,

    // decoder fields
    input  core_pkg::opcode_t  dec_opcode,
    input  core_pkg::reg_idx_t dec_rd_idx,
    input  core_pkg::word_t    dec_imm,
    input  logic [2:0]         dec_funct3,
    input  logic               dec_funct7_b5,

    // register file read data
    input  core_pkg::word_t    rs1_val,
    input  core_pkg::word_t    rs2_val,

    // execute side
    output logic               out_req,
    input  logic               out_ack,
    output core_pkg::opcode_t  out_opcode,
    output core_pkg::reg_idx_t out_rd_idx,
    output core_pkg::word_t    out_rs1_val,
    output core_pkg::word_t    out_rs2_val,
    output core_pkg::word_t    out_imm,
    output logic [2:0]         out_funct3,
    output logic               out_funct7_b5
);

    import core_pkg::*;

    hs_in_state_t  in_state;
    hs_out_state_t out_state;

    // take the instruction only into a free slot
    logic          capture;

    assign capture = in_req && (in_state == in_idle) && (out_state == out_empty);

    // fetch side FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_state <= in_idle;
        end else begin
            case (in_state)
                in_idle: begin
                    if (capture) begin
                        in_state <= in_ack_wait_low;
                    end
                end
                in_ack_wait_low: begin
                    // fetch released the request
                    if (!in_req) begin
                        in_state <= in_hold;
                    end
                end
                in_hold: begin
                    in_state <= in_idle;
                end
                default: begin
                    in_state <= in_idle;
                end
            endcase
        end
    end

    // execute side FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_state <= out_empty;
        end else begin
            case (out_state)
                out_empty: begin
                    if (capture) begin
                        out_state <= out_req_high;
                    end
                end
                out_req_high: begin
                    if (out_ack) begin
                        out_state <= out_wait_ack_low;
                    end
                end
                out_wait_ack_low: begin
                    // slot frees once execute drops ack
                    if (!out_ack) begin
                        out_state <= out_empty;
                    end
                end
                default: begin
                    out_state <= out_empty;
                end
            endcase
        end
    end

    // handshake lines straight from state
    assign in_ack  = (in_state == in_ack_wait_low);
    assign out_req = (out_state == out_req_high);

    // output slot
    // register values sampled before any same-edge writeback
    always_ff @(posedge clk) begin
        if (capture) begin
            out_opcode    <= dec_opcode;
            out_rd_idx    <= dec_rd_idx;
            out_rs1_val   <= rs1_val;
            out_rs2_val   <= rs2_val;
            out_imm       <= dec_imm;
            out_funct3    <= dec_funct3;
            out_funct7_b5 <= dec_funct7_b5;
        end
    end

    // execute must have acked before req may drop
    a_req_fall_after_ack : assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(out_req) |-> $past(out_ack)
    ) else $error("out_req dropped without out_ack");

    // payload frozen while offered
    a_out_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req |=> $stable({out_opcode, out_rd_idx, out_rs1_val, out_rs2_val,
                             out_imm, out_funct3, out_funct7_b5})
    ) else $error("output slot changed while out_req was high");

endmodule : core_s2_ctrl

// ==== hdl/core_s2.sv ====
// decode stage top
// decoder, register file and handshake control

`timescale 1ns/10ps

`include "core_consts.svh"

module core_s2 (
    input  logic               clk,
    input  logic               rst_n,

    // fetch side
    input  logic               in_req,
    input  core_pkg::word_t    in_instr,
    output logic               in_ack,

    // execute side
    output logic               out_req,
    output core_pkg::opcode_t  out_opcode,
    output core_pkg::reg_idx_t out_rd_idx,
    output core_pkg::word_t    out_rs1_val,
    output core_pkg::word_t    out_rs2_val,
    output core_pkg::word_t    out_imm,
    output logic [2:0]         out_funct3,
    output logic               out_funct7_b5,
    input  logic               out_ack,

    // writeback
    input  logic               wb_we,
    input  core_pkg::reg_idx_t wb_idx,
    input  core_pkg::word_t    wb_data
);

    import core_pkg::*;

    // decoder outputs
    opcode_t    dec_opcode;
    reg_idx_t   dec_rd_idx;
    reg_idx_t   dec_rs1_idx;
    reg_idx_t   dec_rs2_idx;
    word_t      dec_imm;
    logic [2:0] dec_funct3;
    logic       dec_funct7_b5;

    // source operands
    word_t      rs1_val;
    word_t      rs2_val;

    core_s2_decoder decoder_i (
        .instr     (in_instr),
        .opcode    (dec_opcode),
        .rd_idx    (dec_rd_idx),
        .rs1_idx   (dec_rs1_idx),
        .rs2_idx   (dec_rs2_idx),
        .imm       (dec_imm),
        .funct3    (dec_funct3),
        .funct7_b5 (dec_funct7_b5)
    );

    // writeback goes straight in
    core_s2_reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_idx  (wb_idx),
        .rd_wd   (wb_data),
        .rd_we   (wb_we),
        .rs1_idx (dec_rs1_idx),
        .rs1_ff  (rs1_val),
        .rs2_idx (dec_rs2_idx),
        .rs2_ff  (rs2_val)
    );

    core_s2_ctrl ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_req        (in_req),
        .in_ack        (in_ack),
        .dec_opcode    (dec_opcode),
        .dec_rd_idx    (dec_rd_idx),
        .dec_imm       (dec_imm),
        .dec_funct3    (dec_funct3),
        .dec_funct7_b5 (dec_funct7_b5),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_opcode    (out_opcode),
        .out_rd_idx    (out_rd_idx),
        .out_rs1_val   (out_rs1_val),
        .out_rs2_val   (out_rs2_val),
        .out_imm       (out_imm),
        .out_funct3    (out_funct3),
        .out_funct7_b5 (out_funct7_b5)
    );

endmodule : core_s2

// ==== verif/core_s2_tb.sv ====
// decode stage testbench
// instruction encoders, reference decode, fetch driver, execute side checker

`timescale 1ns/10ps

`include "core_consts.svh"

module core_s2_tb;

    import core_pkg::*;

    // expected stage output for one instruction
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        word_t      rs1;
        word_t      rs2;
        word_t      imm;
        logic [2:0] funct3;
        logic       funct7_b5;
    } expect_t;

    localparam int timeout_cycles = 200;

    // rv32i major opcodes as full 7-bit fields
    localparam logic [6:0] opc_lui     = 7'b0110111;
    localparam logic [6:0] opc_auipc   = 7'b0010111;
    localparam logic [6:0] opc_jal     = 7'b1101111;
    localparam logic [6:0] opc_jalr    = 7'b1100111;
    localparam logic [6:0] opc_branch  = 7'b1100011;
    localparam logic [6:0] opc_load    = 7'b0000011;
    localparam logic [6:0] opc_store   = 7'b0100011;
    localparam logic [6:0] opc_alu_imm = 7'b0010011;
    localparam logic [6:0] opc_alu_reg = 7'b0110011;

    logic       clk;
    logic       rst_n;
    logic       in_req;
    word_t      in_instr;
    logic       in_ack;
    logic       out_req;
    opcode_t    out_opcode;
    reg_idx_t   out_rd_idx;
    word_t      out_rs1_val;
    word_t      out_rs2_val;
    word_t      out_imm;
    logic [2:0] out_funct3;
    logic       out_funct7_b5;
    logic       out_ack;
    logic       wb_we;
    reg_idx_t   wb_idx;
    word_t      wb_data;

    // register file model with x0 held at zero
    word_t      shadow [`CORE_NUM_REGS];
    // results still owed by the DUT in arrival order
    expect_t    exp_q [$];
    integer     seed;
    int         err_cnt;
    int         check_cnt;
    int         test_cnt;
    int         test_err_base;
    // instruction bookkeeping for ordering checks
    int         sent_cnt;
    int         acked_cnt;
    int         done_cnt;
    int         ack_delay_max;

    core_s2 dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_req        (in_req),
        .in_instr      (in_instr),
        .in_ack        (in_ack),
        .out_req       (out_req),
        .out_opcode    (out_opcode),
        .out_rd_idx    (out_rd_idx),
        .out_rs1_val   (out_rs1_val),
        .out_rs2_val   (out_rs2_val),
        .out_imm       (out_imm),
        .out_funct3    (out_funct3),
        .out_funct7_b5 (out_funct7_b5),
        .out_ack       (out_ack),
        .wb_we         (wb_we),
        .wb_idx        (wb_idx),
        .wb_data       (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one instruction encoder per format
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    // bit 0 of the offset is not encoded
    function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    // expected decode with immediates rebuilt by arithmetic shifts
    function automatic expect_t ref_decode(input word_t instr,
                                           input word_t regs [`CORE_NUM_REGS]);
        expect_t e;
        word_t   sx;
        // all ones for a negative immediate
        sx          = word_t'($signed(instr) >>> 31);
        e.rd        = instr[11:7];
        e.funct3    = instr[14:12];
        e.funct7_b5 = instr[30];
        // x0 reads zero through the model itself
        e.rs1       = regs[instr[19:15]];
        e.rs2       = regs[instr[24:20]];
        e.imm       = '0;
        e.opcode    = op_illegal;
        case (instr[6:0])
            opc_lui: begin
                e.opcode = op_lui;
                e.imm    = instr & 32'hffff_f000;
            end
            opc_auipc: begin
                e.opcode = op_auipc;
                e.imm    = instr & 32'hffff_f000;
            end
            opc_jal: begin
                e.opcode = op_jal;
                e.imm    = (sx << 20) | (word_t'(instr[19:12]) << 12) |
                           (word_t'(instr[20]) << 11) | (word_t'(instr[30:21]) << 1);
            end
            opc_jalr,
            opc_load,
            opc_alu_imm: begin
                e.opcode = (instr[6:0] == opc_jalr) ? op_jalr :
                           (instr[6:0] == opc_load) ? op_load : op_alu_imm;
                e.imm    = word_t'($signed(instr) >>> 20);
            end
            opc_branch: begin
                e.opcode = op_branch;
                e.imm    = (sx << 12) | (word_t'(instr[7]) << 11) |
                           (word_t'(instr[30:25]) << 5) | (word_t'(instr[11:8]) << 1);
            end
            opc_store: begin
                e.opcode = op_store;
                e.imm    = (word_t'($signed(instr) >>> 25) << 5) | word_t'(instr[11:7]);
            end
            opc_alu_reg: begin
                e.opcode = op_alu_reg;
            end
            default: begin
                e.opcode = op_illegal;
            end
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        err_cnt++;
        $display("timeout at %0t: %s", $time, what);
        finish_run();
    endtask

    // writeback while the stage is quiet
    task automatic write_reg(input reg_idx_t idx, input word_t data);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_idx  <= idx;
        wb_data <= data;
        if (idx != '0) begin
            shadow[idx] = data;
        end
        @(posedge clk);
        wb_we <= 1'b0;
    endtask

    // fetch side four-phase handshake with optional writeback on the request edge
    task automatic send_instr(input word_t instr, input logic wb_en,
                              input reg_idx_t wb_i, input word_t wb_d);
        int cnt;
        // predicted before the writeback lands
        exp_q.push_back(ref_decode(instr, shadow));
        sent_cnt++;
        @(posedge clk);
        in_req   <= 1'b1;
        in_instr <= instr;
        if (wb_en) begin
            wb_we   <= 1'b1;
            wb_idx  <= wb_i;
            wb_data <= wb_d;
            if (wb_i != '0) begin
                shadow[wb_i] = wb_d;
            end
        end
        @(posedge clk);
        wb_we <= 1'b0;
        cnt = 0;
        while (in_ack !== 1'b1) begin
            if (cnt >= timeout_cycles) begin
                timeout_abort("in_ack never rose for a pending instruction");
            end
            @(posedge clk);
            cnt++;
        end
        // every earlier result must be retired by now
        check_value("in_ack order", acked_cnt, done_cnt);
        acked_cnt++;
        in_req <= 1'b0;
        cnt = 0;
        while (in_ack !== 1'b0) begin
            if (cnt >= timeout_cycles) begin
                timeout_abort("in_ack stayed high after in_req dropped");
            end
            @(posedge clk);
            cnt++;
        end
    endtask

    task automatic send_plain(input word_t instr);
        send_instr(instr, 1'b0, '0, '0);
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while (done_cnt != sent_cnt) begin
            if (cnt >= timeout_cycles) begin
                timeout_abort("decoded results still outstanding");
            end
            @(posedge clk);
            cnt++;
        end
        // slot frees a cycle after ack drops
        repeat (3) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        drain();
        test_cnt++;
        $display("test %0d %s: %0d mismatches", test_cnt, name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // execute side compares each offered result and acks after a random hold
    initial begin : execute_side
        expect_t e;
        int      hold;
        int      cnt;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n === 1'b1 && out_req === 1'b1) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("result offered at %0t with no instruction outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_value("out_opcode", e.opcode, out_opcode);
                    check_value("out_rd_idx", e.rd, out_rd_idx);
                    check_value("out_rs1_val", e.rs1, out_rs1_val);
                    check_value("out_rs2_val", e.rs2, out_rs2_val);
                    check_value("out_imm", e.imm, out_imm);
                    check_value("out_funct3", e.funct3, out_funct3);
                    check_value("out_funct7_b5", e.funct7_b5, out_funct7_b5);
                end
                hold = {$random(seed)} % (ack_delay_max + 1);
                repeat (hold) @(posedge clk);
                out_ack <= 1'b1;
                cnt = 0;
                @(posedge clk);
                while (out_req !== 1'b0) begin
                    if (cnt >= timeout_cycles) begin
                        timeout_abort("out_req stayed high after out_ack");
                    end
                    @(posedge clk);
                    cnt++;
                end
                out_ack <= 1'b0;
                done_cnt++;
            end
        end
    end

    initial begin : main_flow
        word_t    r;
        word_t    new_val;
        reg_idx_t src;
        reg_idx_t wr_idx [8];
        expect_t  e;
        seed          = 32'ha2b1;
        ack_delay_max = 2;
        rst_n         = 1'b0;
        in_req        = 1'b0;
        in_instr      = '0;
        wb_we         = 1'b0;
        wb_idx        = '0;
        wb_data       = '0;
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            shadow[i] = (i == 0) ? '0 : `CORE_REG_RESET_VAL;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // reset state and reset pattern reads
        check_value("in_ack", 1'b0, in_ack);
        check_value("out_req", 1'b0, out_req);
        send_plain(r_type(7'h00, 5'd0, 5'd5, 3'b000, 5'd1, opc_alu_reg));
        end_test("reset values");

        // writeback then read back with x0 among the targets
        write_reg(5'd0, $random(seed));
        for (int i = 0; i < 8; i++) begin
            wr_idx[i] = reg_idx_t'($random(seed));
            write_reg(wr_idx[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            send_plain(r_type(r[31:25], wr_idx[i], wr_idx[(i + 3) % 8], r[14:12],
                              r[11:7], opc_alu_reg));
        end
        send_plain(r_type(7'h00, wr_idx[0], 5'd0, 3'b000, 5'd2, opc_alu_reg));
        end_test("writeback and read");

        // every class with random fields and both immediate signs
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            send_plain(u_type(r[31:12], r[11:7], opc_lui));
            r = $random(seed);
            send_plain(u_type(r[31:12], r[11:7], opc_auipc));
            r = $random(seed);
            send_plain(j_type(r[20:0], r[11:7]));
            r = $random(seed);
            send_plain(i_type(r[31:20], r[19:15], 3'b000, r[11:7], opc_jalr));
            r = $random(seed);
            send_plain(b_type(r[31:19], r[24:20], r[19:15], r[14:12]));
            r = $random(seed);
            send_plain(i_type(r[31:20], r[19:15], r[14:12], r[11:7], opc_load));
            r = $random(seed);
            send_plain(s_type(r[31:20], r[24:20], r[19:15], r[14:12]));
            r = $random(seed);
            send_plain(i_type(r[31:20], r[19:15], r[14:12], r[11:7], opc_alu_imm));
            r = $random(seed);
            send_plain(r_type(r[31:25], r[24:20], r[19:15], r[14:12], r[11:7],
                              opc_alu_reg));
        end
        end_test("decode and immediates");

        // unsupported major opcodes and non-32-bit encodings
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            if (i % 2 == 0) begin
                r[1:0] = 2'(i / 2);
            end else begin
                r[1:0] = 2'b11;
                e = ref_decode(r, shadow);
                while (e.opcode != op_illegal) begin
                    r[6:2] = 5'($random(seed));
                    e      = ref_decode(r, shadow);
                end
            end
            send_plain(r);
        end
        end_test("illegal instructions");

        // slow execute side makes the second request wait for the slot
        ack_delay_max = 12;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            send_plain(r_type(r[31:25], r[24:20], r[19:15], r[14:12], r[11:7],
                              opc_alu_reg));
        end
        end_test("back-pressure");
        ack_delay_max = 2;

        // writeback on the capture edge stays invisible to that capture
        src     = reg_idx_t'({$random(seed)} % 31 + 1);
        new_val = $random(seed);
        r       = r_type(7'h00, 5'd0, src, 3'b000, 5'd3, opc_alu_reg);
        send_instr(r, 1'b1, src, new_val);
        send_plain(r);
        end_test("same-edge write");

        finish_run();
    end

endmodule : core_s2_tb

// ==== list.f ====
+incdir+include
hdl/core_pkg.sv
hdl/core_s2_reg_file.sv
hdl/core_s2_decoder.sv
hdl/core_s2_ctrl.sv
hdl/core_s2.sv
verif/core_s2_tb.sv

// ==== Bender.yml ====
package:
  name: core_s2

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/core_pkg.sv
      - hdl/core_s2_reg_file.sv
      - hdl/core_s2_decoder.sv
      - hdl/core_s2_ctrl.sv
      - hdl/core_s2.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/core_s2_tb.sv
